// File: verilog.f
+incdir+.
mcu_pkg.sv
obi_bus.sv
sram_bank.sv
ao_periph.sv
gpio_periph.sv
mcu_top.sv
mcu_chk.sv
tb_mcu.sv

// File: tb_mcu.sv
// drives mcu_top through the external master port, one request at a time
// the RAM model only tracks words written by this testbench
`timescale 1ns/1ps
`include "mcu_settings.svh"

module tb_mcu;

  import mcu_pkg::*;

  localparam int DRIVE_DELAY = 10;
  localparam int MEM_WORDS   = `MCU_MEM_BYTES / 4;
  localparam int AW          = $clog2(MEM_WORDS);
  localparam int NUM_STEPS   = 17;
  localparam int DMA_LEN     = 8;
  localparam int TIMEOUT_CYCLES = NUM_STEPS * 10 + DMA_LEN * 20 + 100;

  localparam logic [31:0] RAM_BASE = `MCU_RAM_BASE;
  localparam logic [31:0] AO_BASE  = `MCU_AO_BASE;
  localparam logic [31:0] GPIO_BASE = `MCU_GPIO_BASE;
  localparam logic [31:0] AO_EXIT  = AO_BASE + EXIT_VALUE_OFS;
  localparam logic [31:0] DMA_SRC  = RAM_BASE + 32'h100;
  localparam logic [31:0] DMA_DST  = RAM_BASE + 32'h200;

  // table operations
  localparam logic [1:0] OP_WR       = 2'd0;
  localparam logic [1:0] OP_WR_RND   = 2'd1;
  localparam logic [1:0] OP_RD       = 2'd2;
  localparam logic [1:0] OP_RD_MODEL = 2'd3;

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    logic [31:0] exp;
  } step_t;

  logic        clk;
  logic        rst_n;
  obi_req_t    ext_req;
  obi_resp_t   ext_resp;
  logic [31:0] exit_value;
  logic        exit_valid;
  logic        dma_intr;
  wire  [31:0] gpio_io;
  logic [15:0] pad_hi;

  step_t       steps [NUM_STEPS];
  int          nsteps = 0;
  logic [31:0] ram_model [MEM_WORDS];
  logic [15:0] lfsr_state = 16'd99;
  int          cycles = 0;
  int          errors = 0;

  // high pads come from outside, low pads from the DUT
  assign gpio_io[31:16] = pad_hi;

  mcu_top UUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .ext_master_req_i (ext_req),
    .ext_master_resp_o(ext_resp),
    .exit_value_o     (exit_value),
    .exit_valid_o     (exit_valid),
    .dma_intr_o       (dma_intr),
    .gpio_io          (gpio_io)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles without finishing the tests", cycles);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
    if (addr < RAM_BASE + `MCU_MEM_BYTES) begin
      ram_model[addr[AW+1:2]] = merge_bytes(ram_model[addr[AW+1:2]], data, be);
    end
  endtask

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    return ram_model[addr[AW+1:2]];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  // hold the request until granted, then release it after the grant edge
  task automatic wait_grant();
    @(negedge clk);
    while (!ext_resp.gnt) @(negedge clk);
    @(posedge clk);
    #DRIVE_DELAY;
    ext_req.req = 1'b0;
  endtask

  task automatic wait_rvalid();
    @(negedge clk);
    while (!ext_resp.rvalid) @(negedge clk);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    @(posedge clk);
    #DRIVE_DELAY;
    ext_req.req   = 1'b1;
    ext_req.we    = 1'b1;
    ext_req.be    = be;
    ext_req.addr  = addr;
    ext_req.wdata = data;
    wait_grant();
    wait_rvalid();
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    #DRIVE_DELAY;
    ext_req.req   = 1'b1;
    ext_req.we    = 1'b0;
    ext_req.be    = 4'hF;
    ext_req.addr  = addr;
    ext_req.wdata = '0;
    wait_grant();
    wait_rvalid();
    data = ext_resp.rdata;
  endtask

  task automatic add_step(input logic [1:0] op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] be,
                          input logic [31:0] exp);
    steps[nsteps].op   = op;
    steps[nsteps].addr = addr;
    steps[nsteps].data = data;
    steps[nsteps].be   = be;
    steps[nsteps].exp  = exp;
    nsteps++;
  endtask

  task automatic load_steps();
    add_step(OP_WR_RND,   32'h0000_0000, 32'h0, 4'hF, 32'h0);
    add_step(OP_WR_RND,   32'h0000_0004, 32'h0, 4'hF, 32'h0);
    add_step(OP_WR_RND,   32'h0000_0FFC, 32'h0, 4'hF, 32'h0);
    add_step(OP_WR_RND,   32'h0000_0000, 32'h0, 4'hF, 32'h0);
    add_step(OP_RD_MODEL, 32'h0000_0000, 32'h0, 4'hF, 32'h0);
    add_step(OP_RD_MODEL, 32'h0000_0004, 32'h0, 4'hF, 32'h0);
    add_step(OP_RD_MODEL, 32'h0000_0FFC, 32'h0, 4'hF, 32'h0);
    add_step(OP_WR_RND,   32'h0000_0004, 32'h0, 4'b0101, 32'h0);
    add_step(OP_RD_MODEL, 32'h0000_0004, 32'h0, 4'hF, 32'h0);
    add_step(OP_WR_RND,   32'h0000_0008, 32'h0, 4'hF, 32'h0);
    add_step(OP_WR_RND,   32'h0000_0008, 32'h0, 4'b1000, 32'h0);
    add_step(OP_RD_MODEL, 32'h0000_0008, 32'h0, 4'hF, 32'h0);
    add_step(OP_WR,       AO_EXIT,       32'h0000_00A5, 4'hF, 32'h0);
    add_step(OP_RD,       AO_EXIT,       32'h0, 4'hF, 32'h0000_00A5);
    add_step(OP_RD,       32'h5000_0000, 32'h0, 4'hF, UNMAPPED_RDATA);
    add_step(OP_RD,       32'h0000_1000, 32'h0, 4'hF, UNMAPPED_RDATA);
    add_step(OP_RD_MODEL, 32'h0000_0FFC, 32'h0, 4'hF, 32'h0);
  endtask

  task automatic run_gpio();
    logic [31:0] out_w;
    logic [31:0] rd;
    rand_word(out_w);
    @(posedge clk);
    #DRIVE_DELAY;
    pad_hi = 16'h5A3C;
    bus_write(GPIO_BASE + GPIO_OE_OFS, 32'h0000_FFFF, 4'hF);
    bus_write(GPIO_BASE + GPIO_OUT_OFS, out_w, 4'hF);
    @(negedge clk);
    check_value("gpio_io[15:0]", {16'h0, gpio_io[15:0]}, {16'h0, out_w[15:0]});
    // let the synchroniser catch up
    repeat (2) @(posedge clk);
    bus_read(GPIO_BASE + GPIO_IN_OFS, rd);
    check_value("GPIO_IN", rd, {pad_hi, out_w[15:0]});
    bus_read(GPIO_BASE + GPIO_OE_OFS, rd);
    check_value("GPIO_OE", rd, 32'h0000_FFFF);
  endtask

  task automatic run_dma();
    logic [31:0] w;
    logic [31:0] rd;
    logic [31:0] ctrl;
    int          polls;
    polls = 0;
    for (int i = 0; i < DMA_LEN; i++) begin
      rand_word(w);
      bus_write(DMA_SRC + 4 * i, w, 4'hF);
      model_write(DMA_SRC + 4 * i, w, 4'hF);
    end
    bus_write(AO_BASE + DMA_SRC_OFS, DMA_SRC, 4'hF);
    bus_write(AO_BASE + DMA_DST_OFS, DMA_DST, 4'hF);
    bus_write(AO_BASE + DMA_LEN_OFS, DMA_LEN, 4'hF);
    bus_write(AO_BASE + DMA_CTRL_OFS, 32'h1, 4'hF);
    check_value("dma_intr_o", {31'b0, dma_intr}, 32'h0);
    ctrl = '0;
    while (!ctrl[1]) begin
      // external traffic while the copy runs
      bus_read(DMA_SRC + 4 * (polls % DMA_LEN), rd);
      check_value("src word during copy", rd, model_read(DMA_SRC + 4 * (polls % DMA_LEN)));
      bus_read(AO_BASE + DMA_CTRL_OFS, ctrl);
      polls++;
    end
    check_value("dma_intr_o", {31'b0, dma_intr}, 32'h1);
    for (int i = 0; i < DMA_LEN; i++) begin
      bus_read(DMA_DST + 4 * i, rd);
      check_value($sformatf("dst word %0d", i), rd, model_read(DMA_SRC + 4 * i));
      model_write(DMA_DST + 4 * i, model_read(DMA_SRC + 4 * i), 4'hF);
    end
  endtask

  initial begin
    step_t       s;
    logic [31:0] w;
    logic [31:0] rd;
    clk     = 1'b0;
    rst_n   = 1'b0;
    ext_req = '0;
    pad_hi  = 16'h0000;
    load_steps();
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    check_value("exit_valid_o", {31'b0, exit_valid}, 32'h0);
    check_value("dma_intr_o", {31'b0, dma_intr}, 32'h0);

    for (int i = 0; i < NUM_STEPS; i++) begin
      s = steps[i];
      case (s.op)
        OP_WR_RND: begin
          rand_word(w);
          bus_write(s.addr, w, s.be);
          model_write(s.addr, w, s.be);
        end
        OP_WR: begin
          bus_write(s.addr, s.data, s.be);
          model_write(s.addr, s.data, s.be);
          if (s.addr == AO_EXIT) begin
            check_value("exit_valid_o", {31'b0, exit_valid}, 32'h1);
            check_value("exit_value_o", exit_value, s.data);
          end
        end
        OP_RD: begin
          bus_read(s.addr, rd);
          check_value($sformatf("rdata at %h", s.addr), rd, s.exp);
        end
        default: begin
          bus_read(s.addr, rd);
          check_value($sformatf("rdata at %h", s.addr), rd, model_read(s.addr));
        end
      endcase
    end

    run_gpio();
    run_dma();

    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: mcu_chk.sv
// handshake checks for obi_bus, bound onto every obi_bus instance
`timescale 1ns/1ps

module mcu_chk (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input mcu_pkg::obi_req_t  [1:0] m_req_i,
  input mcu_pkg::obi_resp_t [1:0] m_resp_i
);

  for (genvar i = 0; i < 2; i++) begin : g_master
    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_resp_i[i].gnt |=> m_resp_i[i].rvalid)
      else $error("master %0d: no rvalid one cycle after grant", i);

    // request waiting for a grant must not move
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_req_i[i].req && !m_resp_i[i].gnt |=> m_req_i[i].req && $stable(m_req_i[i]))
      else $error("master %0d: request changed before grant", i);
  end

  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(m_resp_i[0].gnt && m_resp_i[1].gnt))
    else $error("both masters granted in the same cycle");

endmodule

bind obi_bus mcu_chk chk_i (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .m_req_i (m_req_i),
  .m_resp_i(m_resp_o)
);

// File: mcu_top.sv
// bus fabric top, external master on port 0, DMA on port 1
// no CPU, all traffic comes from the external master or the DMA
`timescale 1ns/1ps

module mcu_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  ext_master_req_i,
  output mcu_pkg::obi_resp_t ext_master_resp_o,
  output logic [31:0]        exit_value_o,
  output logic               exit_valid_o,
  output logic               dma_intr_o,
  inout  wire  [31:0]        gpio_io
);

  import mcu_pkg::*;

  // master side
  obi_req_t  [1:0] m_req;
  obi_resp_t [1:0] m_resp;
  obi_req_t        dma_req;
  obi_resp_t       dma_resp;

  // slave side
  obi_req_t        ram_req;
  obi_resp_t       ram_resp;
  obi_req_t        ao_req;
  obi_resp_t       ao_resp;
  obi_req_t        gpio_req;
  obi_resp_t       gpio_resp;

  assign m_req[0]          = ext_master_req_i;
  assign m_req[1]          = dma_req;
  assign ext_master_resp_o = m_resp[0];
  assign dma_resp          = m_resp[1];

  obi_bus obi_bus_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .m_req_i    (m_req),
    .m_resp_o   (m_resp),
    .ram_req_o  (ram_req),
    .ram_resp_i (ram_resp),
    .ao_req_o   (ao_req),
    .ao_resp_i  (ao_resp),
    .gpio_req_o (gpio_req),
    .gpio_resp_i(gpio_resp)
  );

  sram_bank sram_bank_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (ram_req),
    .resp_o (ram_resp)
  );

  ao_periph ao_periph_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .slave_req_i (ao_req),
    .slave_resp_o(ao_resp),
    .dma_req_o   (dma_req),
    .dma_resp_i  (dma_resp),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o),
    .dma_intr_o  (dma_intr_o)
  );

  gpio_periph gpio_periph_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (gpio_req),
    .resp_o (gpio_resp),
    .gpio_io(gpio_io)
  );

endmodule

// File: gpio_periph.sv
// 32 GPIO pads, each driven only where its OE bit is set
// GPIO_IN lags the pads by two clocks through the synchroniser
`timescale 1ns/1ps

module gpio_periph (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  req_i,
  output mcu_pkg::obi_resp_t resp_o,
  inout  wire  [31:0]        gpio_io
);

  import mcu_pkg::*;

  logic [7:0]  ofs;
  logic [31:0] out_q, oe_q;
  logic [31:0] sync1_q, sync2_q;
  logic [31:0] rdata_q;
  logic        rvalid_q;

  assign ofs = req_i.addr[7:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      rdata_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      sync1_q  <= gpio_io;
      sync2_q  <= sync1_q;
      rvalid_q <= req_i.req;
      if (req_i.req && req_i.we) begin
        if (ofs == GPIO_OUT_OFS[7:0]) out_q <= req_i.wdata;
        if (ofs == GPIO_OE_OFS[7:0]) oe_q <= req_i.wdata;
      end else if (req_i.req) begin
        unique case (ofs)
          GPIO_OUT_OFS[7:0]: rdata_q <= out_q;
          GPIO_OE_OFS[7:0]:  rdata_q <= oe_q;
          GPIO_IN_OFS[7:0]:  rdata_q <= sync2_q;
          default:           rdata_q <= '0;
        endcase
      end
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

  // pad tristates
  for (genvar i = 0; i < 32; i++) begin : g_pad
    assign gpio_io[i] = oe_q[i] ? out_q[i] : 1'bz;
  end

endmodule

// File: ao_periph.sv
// exit registers plus a one-channel word-copy DMA
// registers take full-word writes, be is ignored; start is ignored while busy
// addresses must be word aligned, length is clipped to MCU_DMA_MAX_LEN
`timescale 1ns/1ps
`include "mcu_settings.svh"

module ao_periph (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  slave_req_i,
  output mcu_pkg::obi_resp_t slave_resp_o,
  output mcu_pkg::obi_req_t  dma_req_o,
  input  mcu_pkg::obi_resp_t dma_resp_i,
  output logic [31:0]        exit_value_o,
  output logic               exit_valid_o,
  output logic               dma_intr_o
);

  import mcu_pkg::*;

  localparam int CW = $clog2(`MCU_DMA_MAX_LEN + 1);
  localparam logic [CW-1:0] MAX_LEN = CW'(`MCU_DMA_MAX_LEN);

  typedef enum logic [2:0] {IDLE, READ, WAIT_R, WRITE, WAIT_W} dma_state_e;

  logic [7:0]  ofs;
  logic        wr;
  logic        start;
  logic [31:0] src_q, dst_q, len_q;
  logic [31:0] rd_mux;
  logic [31:0] rdata_q;
  logic        rvalid_q;

  dma_state_e  state;
  logic [31:0] src_cur, dst_cur;
  logic [CW-1:0] cnt;
  logic [CW-1:0] len_clip;
  logic [31:0] data_q;
  logic        done_q;

  assign ofs   = slave_req_i.addr[7:0];
  assign wr    = slave_req_i.req & slave_req_i.we;
  assign start = wr && (ofs == DMA_CTRL_OFS[7:0]) && slave_req_i.wdata[0];

  always_comb begin
    unique case (ofs)
      EXIT_VALUE_OFS[7:0]: rd_mux = exit_value_o;
      DMA_SRC_OFS[7:0]:    rd_mux = src_q;
      DMA_DST_OFS[7:0]:    rd_mux = dst_q;
      DMA_LEN_OFS[7:0]:    rd_mux = len_q;
      DMA_CTRL_OFS[7:0]:   rd_mux = {30'b0, done_q, 1'b0};
      default:             rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      rdata_q      <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= slave_req_i.req;
      if (slave_req_i.req && !slave_req_i.we) rdata_q <= rd_mux;
      if (wr) begin
        unique case (ofs)
          EXIT_VALUE_OFS[7:0]: begin
            exit_value_o <= slave_req_i.wdata;
            exit_valid_o <= 1'b1;
          end
          DMA_SRC_OFS[7:0]: src_q <= slave_req_i.wdata;
          DMA_DST_OFS[7:0]: dst_q <= slave_req_i.wdata;
          DMA_LEN_OFS[7:0]: len_q <= slave_req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  assign slave_resp_o.gnt    = slave_req_i.req;
  assign slave_resp_o.rvalid = rvalid_q;
  assign slave_resp_o.rdata  = rdata_q;

  assign len_clip = (len_q > 32'(MAX_LEN)) ? MAX_LEN : len_q[CW-1:0];

  // dma engine, one read then one write per word
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state   <= IDLE;
      src_cur <= '0;
      dst_cur <= '0;
      cnt     <= '0;
      done_q  <= 1'b0;
    end else begin
      unique case (state)
        IDLE: begin
          if (start) begin
            src_cur <= src_q;
            dst_cur <= dst_q;
            cnt     <= len_clip;
            // zero length completes at once
            done_q  <= (len_clip == '0);
            if (len_clip != '0) state <= READ;
          end
        end
        READ:   if (dma_resp_i.gnt) state <= WAIT_R;
        WAIT_R: if (dma_resp_i.rvalid) state <= WRITE;
        WRITE:  if (dma_resp_i.gnt) state <= WAIT_W;
        WAIT_W: begin
          if (dma_resp_i.rvalid) begin
            src_cur <= src_cur + 32'd4;
            dst_cur <= dst_cur + 32'd4;
            cnt     <= cnt - 1'b1;
            if (cnt == CW'(1)) begin
              state  <= IDLE;
              done_q <= 1'b1;
            end else begin
              state <= READ;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == WAIT_R && dma_resp_i.rvalid) data_q <= dma_resp_i.rdata;
  end

  always_comb begin
    dma_req_o.req   = (state == READ) || (state == WRITE);
    dma_req_o.we    = (state == WRITE);
    dma_req_o.be    = 4'hF;
    dma_req_o.addr  = (state == WRITE) ? dst_cur : src_cur;
    dma_req_o.wdata = data_q;
  end

  // level until the next start
  assign dma_intr_o = done_q;

endmodule

// File: sram_bank.sv
// single-port word RAM, address wraps to MCU_MEM_BYTES
// contents are undefined after power up
`timescale 1ns/1ps
`include "mcu_settings.svh"

module sram_bank (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  req_i,
  output mcu_pkg::obi_resp_t resp_o
);

  import mcu_pkg::*;

  localparam int WORDS = `MCU_MEM_BYTES / 4;
  localparam int AW    = $clog2(WORDS);

  logic [31:0]   mem [WORDS];
  logic [AW-1:0] idx;
  logic [31:0]   rdata_q;
  logic          rvalid_q;

  assign idx = req_i.addr[AW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else rvalid_q <= req_i.req;
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

endmodule

// File: obi_bus.sv
// two masters, fixed priority: master 0 always wins a tie
// RAM region is only MCU_MEM_BYTES long, the rest of it reads as unmapped
// slaves must answer exactly one cycle after their grant
`timescale 1ns/1ps
`include "mcu_settings.svh"

module obi_bus (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  mcu_pkg::obi_req_t  [1:0]    m_req_i,
  output mcu_pkg::obi_resp_t [1:0]    m_resp_o,
  output mcu_pkg::obi_req_t           ram_req_o,
  input  mcu_pkg::obi_resp_t          ram_resp_i,
  output mcu_pkg::obi_req_t           ao_req_o,
  input  mcu_pkg::obi_resp_t          ao_resp_i,
  output mcu_pkg::obi_req_t           gpio_req_o,
  input  mcu_pkg::obi_resp_t          gpio_resp_i
);

  import mcu_pkg::*;

  localparam logic [31:0] RAM_BASE  = `MCU_RAM_BASE;
  localparam logic [31:0] AO_BASE   = `MCU_AO_BASE;
  localparam logic [31:0] GPIO_BASE = `MCU_GPIO_BASE;
  localparam logic [27:0] MEM_BYTES = 28'(`MCU_MEM_BYTES);

  logic        any_req;
  logic        win;
  obi_req_t    req_win;
  slave_sel_e  sel;
  logic        slv_gnt;
  logic        gnt;
  logic        rsp_pending;
  logic        rsp_owner;
  slave_sel_e  rsp_sel;
  logic        rvalid;
  logic [31:0] rdata;

  assign any_req = m_req_i[0].req | m_req_i[1].req;
  assign win     = m_req_i[0].req ? 1'b0 : 1'b1;
  assign req_win = m_req_i[win];

  always_comb begin
    sel = SEL_NONE;
    if (req_win.addr[31:28] == RAM_BASE[31:28] && req_win.addr[27:0] < MEM_BYTES) begin
      sel = SEL_RAM;
    end else if (req_win.addr[31:28] == AO_BASE[31:28]) begin
      sel = SEL_AO;
    end else if (req_win.addr[31:28] == GPIO_BASE[31:28]) begin
      sel = SEL_GPIO;
    end
  end

  // full address goes through, slaves keep only the low bits
  always_comb begin
    ram_req_o      = req_win;
    ram_req_o.req  = any_req && (sel == SEL_RAM);
    ao_req_o       = req_win;
    ao_req_o.req   = any_req && (sel == SEL_AO);
    gpio_req_o     = req_win;
    gpio_req_o.req = any_req && (sel == SEL_GPIO);
  end

  always_comb begin
    unique case (sel)
      SEL_RAM:  slv_gnt = ram_resp_i.gnt;
      SEL_AO:   slv_gnt = ao_resp_i.gnt;
      SEL_GPIO: slv_gnt = gpio_resp_i.gnt;
      default:  slv_gnt = 1'b1;
    endcase
  end

  assign gnt = any_req & slv_gnt;

  // owner and target of the granted request, for the response phase
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_pending <= 1'b0;
      rsp_owner   <= 1'b0;
      rsp_sel     <= SEL_NONE;
    end else begin
      rsp_pending <= gnt;
      if (gnt) begin
        rsp_owner <= win;
        rsp_sel   <= sel;
      end
    end
  end

  always_comb begin
    unique case (rsp_sel)
      SEL_RAM: begin
        rvalid = rsp_pending & ram_resp_i.rvalid;
        rdata  = ram_resp_i.rdata;
      end
      SEL_AO: begin
        rvalid = rsp_pending & ao_resp_i.rvalid;
        rdata  = ao_resp_i.rdata;
      end
      SEL_GPIO: begin
        rvalid = rsp_pending & gpio_resp_i.rvalid;
        rdata  = gpio_resp_i.rdata;
      end
      default: begin
        // default responder
        rvalid = rsp_pending;
        rdata  = UNMAPPED_RDATA;
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      m_resp_o[i].gnt    = gnt && (win == i[0]);
      m_resp_o[i].rvalid = rvalid && (rsp_owner == i[0]);
      m_resp_o[i].rdata  = (rvalid && rsp_owner == i[0]) ? rdata : '0;
    end
  end

endmodule

// File: mcu_pkg.sv
// OBI-style bus types, slave select and register offsets
// peripheral offsets are compared on addr[7:0] only
package mcu_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef enum logic [1:0] {
    SEL_RAM  = 2'd0,
    SEL_AO   = 2'd1,
    SEL_GPIO = 2'd2,
    SEL_NONE = 2'd3
  } slave_sel_e;

  // returned for reads that hit no slave
  localparam logic [31:0] UNMAPPED_RDATA = 32'hDEAD_BEEF;

  // always-on block
  localparam logic [31:0] EXIT_VALUE_OFS = 32'h00;
  localparam logic [31:0] DMA_SRC_OFS    = 32'h10;
  localparam logic [31:0] DMA_DST_OFS    = 32'h14;
  localparam logic [31:0] DMA_LEN_OFS    = 32'h18;
  localparam logic [31:0] DMA_CTRL_OFS   = 32'h1C;

  // gpio block
  localparam logic [31:0] GPIO_OUT_OFS = 32'h00;
  localparam logic [31:0] GPIO_OE_OFS  = 32'h04;
  localparam logic [31:0] GPIO_IN_OFS  = 32'h08;

endpackage

// File: mcu_settings.svh
// address map, SRAM size and DMA limits for the fabric
// regions are decoded on addr[31:28], so every base needs its own top nibble
`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

// SRAM size in bytes, power of two
`define MCU_MEM_BYTES 4096

// region bases
`define MCU_RAM_BASE  32'h0000_0000
`define MCU_AO_BASE   32'h2000_0000
`define MCU_GPIO_BASE 32'h3000_0000

// longer DMA transfers are clipped to this many words
`define MCU_DMA_MAX_LEN 64

`endif
